//--- common/board_pkg.sv
package board_pkg;

    localparam int clk_mhz = 50;                   // board oscillator.

    localparam int w_key   = 3;                    // up, down, clear keys.
    localparam int w_sw    = 3;                    // switches, mirrored from keys.
    localparam int w_led   = 4;
    localparam int w_digit = 8;                    // eight hex digits.
    localparam int w_gpio  = 2;

    localparam int w_count = 32;                   // event counter width.

    localparam int debounce_cycles_default = clk_mhz * 1000;  // 1 ms at clk_mhz.
    localparam int scan_cycles_default     = clk_mhz * 1000;  // 1 ms per digit.

    // 640x480 at 60 Hz, one pixel per clock.
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;

    localparam int h_total = h_visible + h_front + h_sync + h_back;  // 800.
    localparam int v_total = v_visible + v_front + v_sync + v_back;  // 525.

    typedef struct packed {
        logic up;                                  // key 0.
        logic down;                                // key 1.
        logic clear;                               // key 2.
    } key_event_t;

    typedef struct packed {
        logic       hsync;                         // active low.
        logic       vsync;                         // active low.
        logic       display_on;                    // inside visible area.
        logic [9:0] x;
        logic [9:0] y;
    } vga_timing_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // segment a in bit 7 down to g in bit 1, dp in bit 0 stays dark.
    function automatic logic [7:0] hex_to_abcdefgh(input logic [3:0] nibble);
        logic [7:0] seg;
        case (nibble)
            4'h0: seg = 8'b1111_1100;
            4'h1: seg = 8'b0110_0000;
            4'h2: seg = 8'b1101_1010;
            4'h3: seg = 8'b1111_0010;
            4'h4: seg = 8'b0110_0110;
            4'h5: seg = 8'b1011_0110;
            4'h6: seg = 8'b1011_1110;
            4'h7: seg = 8'b1110_0000;
            4'h8: seg = 8'b1111_1110;
            4'h9: seg = 8'b1111_0110;
            4'ha: seg = 8'b1110_1110;
            4'hb: seg = 8'b0011_1110;
            4'hc: seg = 8'b1001_1100;
            4'hd: seg = 8'b0111_1010;
            4'he: seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;           // f.
        endcase
        return seg;
    endfunction

endpackage

//--- hw/key_debouncer.sv
`timescale 1ns/1ps

module key_debouncer
    import board_pkg::*;
#(
    parameter int debounce_cycles = debounce_cycles_default
)(
    input  logic             clk,
    input  logic             reset,
    input  logic [w_key-1:0] key,                  // active high, asynchronous.
    output logic             event_valid,          // one cycle per accepted press.
    output key_event_t       event_data
);

    localparam int w_cnt = $clog2(debounce_cycles + 1);

    logic [w_key-1:0] sync_meta;                   // first synchroniser stage.
    logic [w_key-1:0] sync_q;                      // second stage, safe to use.
    logic [w_key-1:0] stable;                      // debounced level per key.
    logic [w_cnt-1:0] stable_cnt [w_key];          // cycles the new level has held.
    logic [w_key-1:0] settle;                      // new level accepted this cycle.
    logic [w_key-1:0] press;                       // accepted level is a press.

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= key;
            sync_q    <= sync_meta;
        end
    end

    // accept once the differing level has held for debounce_cycles cycles.
    always_comb begin
        for (int i = 0; i < w_key; i++) begin
            settle[i] = (sync_q[i] != stable[i])
                     && (stable_cnt[i] == w_cnt'(debounce_cycles - 1));
        end
    end

    assign press = settle & sync_q;                // release-to-press only.

    always_ff @(posedge clk) begin
        if (reset) begin
            stable <= '0;
            for (int i = 0; i < w_key; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < w_key; i++) begin
                if (sync_q[i] == stable[i]) begin
                    stable_cnt[i] <= '0;           // bounce back, restart.
                end else if (settle[i]) begin
                    stable[i]     <= sync_q[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // pulse lands one cycle after acceptance.
    always_ff @(posedge clk) begin
        if (reset) begin
            event_valid <= 1'b0;
            event_data  <= '0;
        end else begin
            event_valid      <= |press;
            event_data.up    <= press[0];
            event_data.down  <= press[1];
            event_data.clear <= press[2];
        end
    end

endmodule

//--- hw/event_counter.sv
`timescale 1ns/1ps

module event_counter
    import board_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               event_valid,        // always accepted.
    input  key_event_t         event_data,
    output logic [w_count-1:0] count
);

    logic up_only;                                 // up without down.
    logic down_only;                               // down without up.

    assign up_only   = event_data.up & ~event_data.down;
    assign down_only = event_data.down & ~event_data.up;

    // clear wins, up and down together cancel.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (event_valid) begin
            if (event_data.clear) begin
                count <= '0;
            end else if (up_only) begin
                count <= count + 1'b1;             // wraps at 2**32.
            end else if (down_only) begin
                count <= count - 1'b1;             // 0 wraps to all ones.
            end
        end
    end

endmodule

//--- display/seven_seg_scanner.sv
`timescale 1ns/1ps

module seven_seg_scanner
    import board_pkg::*;
#(
    parameter int scan_cycles = scan_cycles_default
)(
    input  logic               clk,
    input  logic               reset,
    input  logic [w_count-1:0] value,              // shown as hex.
    output logic [7:0]         abcdefgh,           // active high segments.
    output logic [w_digit-1:0] digit               // one-hot strobe, active high.
);

    localparam int w_pre = $clog2(scan_cycles + 1);
    localparam int w_idx = $clog2(w_digit);

    logic [w_pre-1:0] prescale;                    // dwell time per digit.
    logic [w_idx-1:0] digit_idx;                   // digit being driven.
    logic             dwell_done;
    logic [3:0]       nibble;

    assign dwell_done = prescale == w_pre'(scan_cycles - 1);
    assign nibble     = value[digit_idx * 4 +: 4]; // digit 0 is the low nibble.

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale  <= '0;
            digit_idx <= '0;
        end else if (dwell_done) begin
            prescale <= '0;
            if (digit_idx == w_idx'(w_digit - 1)) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 1'b1;
            end
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // strobe and segments share one register stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            digit    <= w_digit'(1);                // start at digit 0.
            abcdefgh <= '0;
        end else begin
            digit    <= w_digit'(1) << digit_idx;
            abcdefgh <= hex_to_abcdefgh(nibble);
        end
    end

endmodule

//--- vga/vga_sync_gen.sv
`timescale 1ns/1ps

module vga_sync_gen
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output vga_timing_t timing                     // registered, one pixel per clock.
);

    localparam int h_sync_start = h_visible + h_front;      // 656.
    localparam int h_sync_end   = h_sync_start + h_sync;    // 752, exclusive.
    localparam int v_sync_start = v_visible + v_front;      // 490.
    localparam int v_sync_end   = v_sync_start + v_sync;    // 492, exclusive.

    logic [9:0] h_cnt;                             // pixel within line.
    logic [9:0] v_cnt;                             // line within frame.
    logic       line_end;
    logic       frame_end;
    logic       h_in_sync;
    logic       v_in_sync;

    assign line_end  = h_cnt == 10'(h_total - 1);
    assign frame_end = v_cnt == 10'(v_total - 1);

    assign h_in_sync = (h_cnt >= 10'(h_sync_start)) && (h_cnt < 10'(h_sync_end));
    assign v_in_sync = (v_cnt >= 10'(v_sync_start)) && (v_cnt < 10'(v_sync_end));

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timing.hsync      <= 1'b1;             // syncs idle high.
            timing.vsync      <= 1'b1;
            timing.display_on <= 1'b0;
            timing.x          <= '0;
            timing.y          <= '0;
        end else begin
            timing.hsync      <= ~h_in_sync;
            timing.vsync      <= ~v_in_sync;
            timing.display_on <= (h_cnt < 10'(h_visible)) && (v_cnt < 10'(v_visible));
            timing.x          <= h_cnt;
            timing.y          <= v_cnt;
        end
    end

endmodule

//--- vga/vga_pattern.sv
`timescale 1ns/1ps

module vga_pattern
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  vga_timing_t timing,
    input  logic [2:0]  highlight,                 // bar shown white.
    output logic        hsync,                     // delayed to match colour.
    output logic        vsync,
    output rgb_t        colour
);

    localparam int bar_width = h_visible / 8;      // 80 pixels per bar.

    logic [2:0] bar;                               // bar under the beam.
    rgb_t       colour_next;

    assign bar = 3'(timing.x / 10'(bar_width));

    always_comb begin
        colour_next = '0;                          // black in blanking.
        if (timing.display_on) begin
            if (bar == highlight) begin
                colour_next = '1;                  // white bar.
            end else begin
                colour_next.red   = {4{bar[2]}};
                colour_next.green = {4{bar[1]}};
                colour_next.blue  = {4{bar[0]}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            colour <= '0;
        end else begin
            hsync  <= timing.hsync;                // keep syncs aligned with colour.
            vsync  <= timing.vsync;
            colour <= colour_next;
        end
    end

endmodule

//--- hw/top.sv
`timescale 1ns/1ps

module top
    import board_pkg::*;
#(
    parameter int debounce_cycles = debounce_cycles_default,
    parameter int scan_cycles     = scan_cycles_default
)(
    input  logic               clk,
    input  logic               reset,
    input  logic [w_key-1:0]   key,                // active high.
    input  logic [w_sw-1:0]    sw,                 // unused in this demo.
    output logic [w_led-1:0]   led,
    output logic [7:0]         abcdefgh,
    output logic [w_digit-1:0] digit,
    output logic               hsync,
    output logic               vsync,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue,
    input  logic [23:0]        mic,                // unused in this demo.
    inout  wire  [w_gpio-1:0]  gpio
);

    logic               event_valid;
    key_event_t         event_data;
    logic [w_count-1:0] count;
    vga_timing_t        timing;
    rgb_t               colour;

    key_debouncer #(
        .debounce_cycles ( debounce_cycles )
    ) i_debouncer (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .key         ( key         ),
        .event_valid ( event_valid ),
        .event_data  ( event_data  )
    );

    event_counter i_counter (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .event_valid ( event_valid ),
        .event_data  ( event_data  ),
        .count       ( count       )
    );

    seven_seg_scanner #(
        .scan_cycles ( scan_cycles )
    ) i_scanner (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .value    ( count    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    vga_sync_gen i_sync (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .timing ( timing )
    );

    vga_pattern i_pattern (
        .clk       ( clk        ),
        .reset     ( reset      ),
        .timing    ( timing     ),
        .highlight ( count[2:0] ),                 // selected bar follows count.
        .hsync     ( hsync      ),
        .vsync     ( vsync      ),
        .colour    ( colour     )
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            led <= '0;
        end else begin
            led <= count[w_led-1:0];               // low count bits.
        end
    end

    assign red   = colour.red;
    assign green = colour.green;
    assign blue  = colour.blue;

    assign gpio = 'z;                              // not driven in this demo.

endmodule

//--- hw/board_specific_top.sv
`timescale 1ns/1ps

module board_specific_top
    import board_pkg::*;
#(
    parameter int debounce_cycles = debounce_cycles_default,
    parameter int scan_cycles     = scan_cycles_default
)(
    input  logic               CLK,
    input  logic               RST_N,              // active low.
    input  logic [w_key-1:0]   KEY,                // active low.
    output logic [w_led-1:0]   LED,                // active low.
    output logic [7:0]         SEG_DATA,
    output logic [w_digit-1:0] SEG_SEL,
    output logic               VGA_OUT_HS,
    output logic               VGA_OUT_VS,
    output logic [4:0]         VGA_OUT_R,
    output logic [5:0]         VGA_OUT_G,
    output logic [4:0]         VGA_OUT_B,
    output logic [2:0]         VGA_RGB,
    input  logic               UART_RXD,           // receiver not fitted here.
    inout  wire  [w_gpio-1:0]  GPIO
);

    logic [w_led-1:0] led;
    logic [3:0]       red;
    logic [3:0]       green;
    logic [3:0]       blue;

    top #(
        .debounce_cycles ( debounce_cycles ),
        .scan_cycles     ( scan_cycles     )
    ) i_top (
        .clk      (   CLK        ),
        .reset    ( ~ RST_N      ),
        .key      ( ~ KEY        ),
        .sw       ( ~ KEY        ),            // keys double as switches.
        .led      (   led        ),
        .abcdefgh (   SEG_DATA   ),
        .digit    (   SEG_SEL    ),
        .hsync    (   VGA_OUT_HS ),
        .vsync    (   VGA_OUT_VS ),
        .red      (   red        ),
        .green    (   green      ),
        .blue     (   blue       ),
        .mic      (   24'd0      ),            // no microphone.
        .gpio     (   GPIO       )
    );

    assign LED = ~led;

    // widen each colour by repeating its top bit.
    assign VGA_OUT_R = {red, red[3]};
    assign VGA_OUT_G = {green, {2{green[3]}}};
    assign VGA_OUT_B = {blue, blue[3]};

    assign VGA_RGB = {|red, |green, |blue};   // 1-bit colour pins.

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
    import board_pkg::*;
(
    input  logic               clk,
    input  logic [w_led-1:0]   led_n,              // board pins, active low.
    input  logic [7:0]         seg_data,
    input  logic [w_digit-1:0] seg_sel,
    input  logic               hs,
    input  logic               vs,
    input  logic [4:0]         vga_r,
    input  logic [5:0]         vga_g,
    input  logic [4:0]         vga_b,
    input  logic [2:0]         vga_rgb             // 1-bit colour pins.
);

    localparam int bar_width    = 80;
    localparam int hs_fall_x    = h_visible + h_front;       // x where hsync drops.
    localparam int first_line   = v_total - (v_visible + v_front); // falls to line 0.
    localparam int scan_timeout = 256;

    logic [w_count-1:0] model_count;               // expected counter value.
    string              test_name;
    int                 error_count;
    int                 errors_at_start;
    int                 tests_run;
    int                 tests_failed;
    logic               hs_prev;
    logic               vs_prev;

    initial begin
        model_count  = '0;
        test_name    = "none";
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        hs_prev      = 1'b1;
        vs_prev      = 1'b1;
    end

    // clear first, up with down cancels, wraps at 32 bits.
    function automatic logic [w_count-1:0] next_count(input logic [w_count-1:0] cnt,
                                                     input logic [2:0] keys);
        if (keys[2]) return '0;
        if (keys[0] && !keys[1]) return cnt + 1'b1;
        if (keys[1] && !keys[0]) return cnt - 1'b1;
        return cnt;
    endfunction

    // abcdefg then dp; bit 4 of the result flags a known digit.
    function automatic logic [4:0] seg_to_hex(input logic [7:0] seg);
        case (seg)
            8'b1111110_0: return 5'h10;
            8'b0110000_0: return 5'h11;
            8'b1101101_0: return 5'h12;
            8'b1111001_0: return 5'h13;
            8'b0110011_0: return 5'h14;
            8'b1011011_0: return 5'h15;
            8'b1011111_0: return 5'h16;
            8'b1110000_0: return 5'h17;
            8'b1111111_0: return 5'h18;
            8'b1111011_0: return 5'h19;
            8'b1110111_0: return 5'h1a;
            8'b0011111_0: return 5'h1b;
            8'b1001110_0: return 5'h1c;
            8'b0111101_0: return 5'h1d;
            8'b1001111_0: return 5'h1e;
            8'b1000111_0: return 5'h1f;
            default:      return 5'h00;
        endcase
    endfunction

    function automatic logic is_onehot(input logic [w_digit-1:0] v);
        return (v != '0) && ((v & (v - 1'b1)) == '0);
    endfunction

    // eight bars by x, highlighted one white, black outside the visible area.
    function automatic logic [11:0] colour_rule(input logic disp, input int x,
                                                input logic [2:0] highlight);
        int bar;
        if (!disp) return 12'h000;
        bar = x / bar_width;
        if (bar[2:0] == highlight) return 12'hfff;
        return {{4{bar[2]}}, {4{bar[1]}}, {4{bar[0]}}};
    endfunction

    // pin view: top bit repeated into the extra lsbs.
    function automatic logic [15:0] widen_colour(input logic [11:0] c);
        return {c[11:8], c[11], c[7:4], {2{c[7]}}, c[3:0], c[3]};
    endfunction

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        int fails;
        fails = error_count - errors_at_start;
        tests_run++;
        if (fails == 0) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name, fails);
        end
    endtask

    task automatic report_mismatch(input string what, input string exp_text,
                                   input string act_text);
        error_count++;
        $display("mismatch %s %s: expected %s, actual %s", test_name, what, exp_text, act_text);
    endtask

    task automatic report_failure(input string text);
        error_count++;
        $display("error in %s: %s", test_name, text);
    endtask

    task automatic apply_press(input logic [2:0] keys);
        model_count = next_count(model_count, keys);
    endtask

    // one full scan, each strobed digit decoded back to a nibble.
    task automatic check_display();
        logic [w_count-1:0] shown;
        logic [w_digit-1:0] seen;
        logic [w_led-1:0]   led_shown;
        logic [4:0]         hex;
        int                 cycles;
        shown  = '0;
        seen   = '0;
        cycles = 0;
        while (seen != '1 && cycles < scan_timeout) begin
            @(negedge clk);
            cycles++;
            if (!is_onehot(seg_sel)) begin
                report_failure($sformatf("digit strobe %b is not one-hot", seg_sel));
                return;
            end
            for (int i = 0; i < w_digit; i++) begin
                if (seg_sel[i] && !seen[i]) begin
                    hex = seg_to_hex(seg_data);
                    if (!hex[4]) begin
                        report_failure($sformatf("digit %0d shows unknown segments %b",
                                                 i, seg_data));
                    end
                    shown[i*4 +: 4] = hex[3:0];
                    seen[i]         = 1'b1;
                end
            end
        end
        if (seen != '1) begin
            report_failure("display scan did not reach all eight digits");
        end else if (shown != model_count) begin
            report_mismatch("display", $sformatf("%h", model_count), $sformatf("%h", shown));
        end
        led_shown = ~led_n;
        if (led_shown != model_count[w_led-1:0]) begin
            report_mismatch("leds", $sformatf("%h", model_count[w_led-1:0]),
                            $sformatf("%h", led_shown));
        end
    endtask

    // one pixel step, edges taken against the previous sample.
    task automatic step_vga(output logic hs_fall, output logic hs_rise, output logic vs_fall);
        @(negedge clk);
        hs_fall = hs_prev && !hs;
        hs_rise = !hs_prev && hs;
        vs_fall = vs_prev && !vs;
        hs_prev = hs;
        vs_prev = vs;
    endtask

    // measures from one vsync fall to the next.
    task automatic check_vga_sync();
        logic hf;
        logic hr;
        logic vf;
        int   cyc;
        int   last_fall;
        int   hs_low;
        int   vs_low;
        int   lines;
        step_vga(hf, hr, vf);                      // refresh stale history.
        vf = 1'b0;
        while (!vf) step_vga(hf, hr, vf);
        cyc       = 0;
        last_fall = -1;
        hs_low    = 0;
        vs_low    = 1;                             // the edge sample is already low.
        lines     = 0;
        vf        = 1'b0;
        while (!vf) begin
            step_vga(hf, hr, vf);
            cyc++;
            if (!vf) begin
                if (!vs) vs_low++;
                if (hf) begin
                    if (last_fall >= 0 && cyc - last_fall != h_total) begin
                        report_mismatch("hsync period", $sformatf("%0d", h_total),
                                        $sformatf("%0d", cyc - last_fall));
                    end
                    last_fall = cyc;
                    lines++;
                    hs_low = 1;
                end else if (!hs) begin
                    hs_low++;
                end
                if (hr && hs_low != h_sync) begin
                    report_mismatch("hsync low width", $sformatf("%0d", h_sync),
                                    $sformatf("%0d", hs_low));
                end
            end
        end
        if (cyc != h_total * v_total) begin
            report_mismatch("vsync period cycles", $sformatf("%0d", h_total * v_total),
                            $sformatf("%0d", cyc));
        end
        if (lines != v_total) begin
            report_mismatch("hsync periods per frame", $sformatf("%0d", v_total),
                            $sformatf("%0d", lines));
        end
        if (vs_low != v_sync * h_total) begin
            report_mismatch("vsync low cycles", $sformatf("%0d", v_sync * h_total),
                            $sformatf("%0d", vs_low));
        end
    endtask

    // from an hsync fall, checks blanking and bar centres of the next line.
    task automatic check_line(input logic visible);
        logic        hf;
        logic        hr;
        logic        vf;
        logic        disp;
        logic [11:0] model_colour;
        logic [18:0] expected;
        logic [18:0] actual;
        int          x;
        for (int off = 0; off < h_total; off++) begin
            if (off > 0) step_vga(hf, hr, vf);
            x    = (hs_fall_x + off) % h_total;
            disp = visible && (x < h_visible);
            if (x >= h_visible || (x % bar_width) == bar_width / 2) begin
                model_colour = colour_rule(disp, x, model_count[2:0]);
                expected     = {widen_colour(model_colour), |model_colour[11:8],
                                |model_colour[7:4], |model_colour[3:0]};
                actual       = {vga_r, vga_g, vga_b, vga_rgb};
                if (actual !== expected) begin
                    report_mismatch($sformatf("pixel x %0d", x), $sformatf("%h", expected),
                                    $sformatf("%h", actual));
                end
            end
        end
    endtask

    // starts right after a vsync fall, i.e. at line v_visible + v_front.
    task automatic check_colour_bars();
        logic hf;
        logic hr;
        logic vf;
        int   falls;
        falls = 0;
        while (falls < first_line + 1) begin
            step_vga(hf, hr, vf);
            if (hf) begin
                falls++;
                if (falls == 1) begin
                    check_line(1'b0);              // vertical blanking line.
                end else if (falls >= first_line) begin
                    check_line(1'b1);              // lines 0 and 1.
                end
            end
        end
    endtask

    task automatic final_report(output int failures);
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        failures = error_count;
    endtask

endmodule

//--- sim/tb_board.sv
`timescale 1ns/1ps

module tb_board
    import board_pkg::*;
();

    localparam int debounce_cycles  = 16;          // shortened for simulation.
    localparam int scan_cycles      = 4;
    localparam int hold_cycles      = 40;          // settled time per press and release.
    localparam int glitch_count     = 3;
    localparam int fixed_presses    = 3;           // down, clear, up with down.
    localparam int cycles_per_press = 4000;

    logic               clk;
    logic               rst_n;
    logic [w_key-1:0]   key_n;                     // active low, as on the board.
    logic               uart_rxd;
    logic [w_led-1:0]   led_n;
    logic [7:0]         seg_data;
    logic [w_digit-1:0] seg_sel;
    logic               vga_hs;
    logic               vga_vs;
    logic [4:0]         vga_r;
    logic [5:0]         vga_g;
    logic [4:0]         vga_b;
    logic [2:0]         vga_rgb;
    wire  [w_gpio-1:0]  gpio;                      // left floating.

    int cycle_count = 0;
    int cycle_limit = 1_000_000;                   // replaced once the press count is known.
    int up_presses;
    int failures;

    board_specific_top #(
        .debounce_cycles ( debounce_cycles ),
        .scan_cycles     ( scan_cycles     )
    ) board_specific_top_i (
        .CLK        ( clk      ),
        .RST_N      ( rst_n    ),
        .KEY        ( key_n    ),
        .LED        ( led_n    ),
        .SEG_DATA   ( seg_data ),
        .SEG_SEL    ( seg_sel  ),
        .VGA_OUT_HS ( vga_hs   ),
        .VGA_OUT_VS ( vga_vs   ),
        .VGA_OUT_R  ( vga_r    ),
        .VGA_OUT_G  ( vga_g    ),
        .VGA_OUT_B  ( vga_b    ),
        .VGA_RGB    ( vga_rgb  ),
        .UART_RXD   ( uart_rxd ),
        .GPIO       ( gpio     )
    );

    tb_checker tb_checker_i (
        .clk      ( clk      ),
        .led_n    ( led_n    ),
        .seg_data ( seg_data ),
        .seg_sel  ( seg_sel  ),
        .hs       ( vga_hs   ),
        .vs       ( vga_vs   ),
        .vga_r    ( vga_r    ),
        .vga_g    ( vga_g    ),
        .vga_b    ( vga_b    ),
        .vga_rgb  ( vga_rgb  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                     // 4 ns period.
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // masked keys chatter in step for fewer than debounce_cycles cycles.
    task automatic bounce_keys(input logic [w_key-1:0] mask);
        int chatter;
        chatter = $urandom_range(debounce_cycles - 1, 1);
        repeat (chatter) begin
            @(negedge clk);
            key_n = ~(mask & {w_key{1'($urandom)}});
        end
    endtask

    // bouncy press, hold, bouncy release, hold.
    task automatic press_keys(input logic [w_key-1:0] mask);
        bounce_keys(mask);
        @(negedge clk);
        key_n = ~mask;
        repeat (hold_cycles) @(negedge clk);
        bounce_keys(mask);
        @(negedge clk);
        key_n = '1;
        repeat (hold_cycles) @(negedge clk);
        tb_checker_i.apply_press(mask);            // model follows the settled press.
    endtask

    // pressed window stays under debounce_cycles, so no event.
    task automatic glitch_key(input logic [w_key-1:0] mask);
        int width;
        width = $urandom_range(debounce_cycles - 1, 1);
        @(negedge clk);
        key_n = ~mask;
        repeat (width - 1) begin
            @(negedge clk);
            key_n = ~(mask & 3'($urandom));
        end
        @(negedge clk);
        key_n = '1;
        repeat (hold_cycles) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h74d8_cda7));
        rst_n     = 1'b0;
        key_n     = '1;                            // nothing pressed.
        uart_rxd  = 1'b1;                          // idle line.
        up_presses  = $urandom_range(10, 3);
        cycle_limit = 2 * h_total * v_total
                    + cycles_per_press * (up_presses + glitch_count + fixed_presses);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        tb_checker_i.begin_test("down_wrap");
        tb_checker_i.check_display();              // zero after reset.
        press_keys(3'b010);
        tb_checker_i.check_display();              // wraps to all ones.
        press_keys(3'b100);
        tb_checker_i.check_display();
        press_keys(3'b011);                        // up and down cancel.
        tb_checker_i.check_display();
        tb_checker_i.end_test();

        tb_checker_i.begin_test("up_presses");
        repeat (up_presses) begin
            press_keys(3'b001);
            tb_checker_i.check_display();
        end
        tb_checker_i.end_test();

        tb_checker_i.begin_test("bounce_reject");
        repeat (glitch_count) begin
            glitch_key(3'b001 << $urandom_range(2, 0));
            tb_checker_i.check_display();          // nonzero count, so a clear shows too.
        end
        tb_checker_i.end_test();

        tb_checker_i.begin_test("vga_sync");
        tb_checker_i.check_vga_sync();
        tb_checker_i.end_test();

        tb_checker_i.begin_test("colour_bars");
        tb_checker_i.check_colour_bars();          // picks up at the last vsync edge.
        tb_checker_i.end_test();

        tb_checker_i.final_report(failures);
        if (failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
common/board_pkg.sv
hw/key_debouncer.sv
hw/event_counter.sv
display/seven_seg_scanner.sv
vga/vga_sync_gen.sv
vga/vga_pattern.sv
hw/top.sv
hw/board_specific_top.sv
sim/tb_checker.sv
sim/tb_board.sv

//--- Bender.yml
package:
  name: board_demo

sources:
  - common/board_pkg.sv
  - hw/key_debouncer.sv
  - hw/event_counter.sv
  - display/seven_seg_scanner.sv
  - vga/vga_sync_gen.sv
  - vga/vga_pattern.sv
  - hw/top.sv
  - hw/board_specific_top.sv
  - target: simulation
    files:
      - sim/tb_checker.sv
      - sim/tb_board.sv
